// File: list.f
+incdir+verification
source/csr_pkg.sv
source/csr_port_if.sv
source/csr_access.sv
source/csr_machine_regs.sv
source/csr_top.sv
verification/csr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module csr_tb \
  -o csr_sim

./obj_dir/csr_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// File: source/csr_access.sv
/*
 * CSR access decoder
 * Maps the address to a register select, checks existence, privilege
 * and read-only rules, and forms the read-modify-write value
 */
`timescale 1ns/1ps

module csr_access (
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::xlen_t     csr_wdata,     // rs1 or zero-extended uimm
  input  csr_pkg::csr_op_e   csr_op,
  input  logic               csr_we,
  input  csr_pkg::priv_t     current_priv,
  output logic               illegal_csr,
  csr_port_if.access         port
);

  csr_pkg::csr_sel_e sel;
  logic              addr_exists;
  logic              addr_ro;
  logic              priv_ok;
  csr_pkg::priv_t    addr_priv;

  // ==================================================
  // Address decode
  // ==================================================
  always_comb begin
    case (csr_addr)
      csr_pkg::ADDR_MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
      csr_pkg::ADDR_MISA:      sel = csr_pkg::SEL_MISA;
      csr_pkg::ADDR_MIE:       sel = csr_pkg::SEL_MIE;
      csr_pkg::ADDR_MTVEC:     sel = csr_pkg::SEL_MTVEC;
      csr_pkg::ADDR_MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
      csr_pkg::ADDR_MEPC:      sel = csr_pkg::SEL_MEPC;
      csr_pkg::ADDR_MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
      csr_pkg::ADDR_MTVAL:     sel = csr_pkg::SEL_MTVAL;
      csr_pkg::ADDR_MIP:       sel = csr_pkg::SEL_MIP;
      csr_pkg::ADDR_MVENDORID: sel = csr_pkg::SEL_MVENDORID;
      csr_pkg::ADDR_MARCHID:   sel = csr_pkg::SEL_MARCHID;
      csr_pkg::ADDR_MIMPID:    sel = csr_pkg::SEL_MIMPID;
      csr_pkg::ADDR_MHARTID:   sel = csr_pkg::SEL_MHARTID;
      default: begin
        // Whole 0x7xx page is accepted as test space
        if (csr_addr[11:8] == csr_pkg::ADDR_TEST_PAGE) begin
          sel = csr_pkg::SEL_TEST;
        end else begin
          sel = csr_pkg::SEL_NONE;
        end
      end
    endcase
  end

  assign port.sel = sel;

  // ==================================================
  // Legality checks
  // ==================================================
  assign addr_exists = (sel != csr_pkg::SEL_NONE);
  assign addr_priv   = csr_addr[csr_pkg::ADDR_PRIV_HI:csr_pkg::ADDR_PRIV_LO];
  assign priv_ok     = (current_priv >= addr_priv);     // Need at least the CSR level

  // Bits 11:10 == 3 marks the read-only space, misa is hardwired too
  assign addr_ro = (csr_addr[11:10] == 2'b11) || (sel == csr_pkg::SEL_MISA);

  // Only writes are checked, every CSR instruction raises csr_we
  assign illegal_csr = csr_we && (!addr_exists || !priv_ok || addr_ro);

  // ==================================================
  // Read-modify-write
  // ==================================================
  always_comb begin
    case (csr_op)
      csr_pkg::CSR_RW,
      csr_pkg::CSR_RWI: port.wr_value = csr_wdata;                 // Plain write
      csr_pkg::CSR_RS,
      csr_pkg::CSR_RSI: port.wr_value = port.rdata | csr_wdata;    // Set bits
      csr_pkg::CSR_RC,
      csr_pkg::CSR_RCI: port.wr_value = port.rdata & ~csr_wdata;   // Clear bits
      default:          port.wr_value = port.rdata;                // No change
    endcase
  end

  // Store only what passed every check
  assign port.wr_en = csr_we && !illegal_csr;

endmodule

// File: source/csr_machine_regs.sv
/*
 * Machine CSR bank
 * Holds mstatus fields and the machine trap registers, applies CSR
 * writes, trap entry and MRET, and drives the read value for a select
 */
`timescale 1ns/1ps

module csr_machine_regs (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                trap_entry,
  input  csr_pkg::xlen_t      trap_pc,
  input  csr_pkg::cause_t     trap_cause,
  input  csr_pkg::xlen_t      trap_val,
  input  logic                mret,
  input  csr_pkg::priv_t      current_priv,
  csr_port_if.regs            port,
  output csr_pkg::xlen_t      trap_vector,
  output csr_pkg::xlen_t      mepc_out,
  output logic                mstatus_mie,
  output csr_pkg::priv_t      mpp_out
);

  // mstatus fields, everything else reads as zero
  logic           mie_q;
  logic           mpie_q;
  csr_pkg::priv_t mpp_q;

  // Full-width machine registers
  csr_pkg::xlen_t mie_reg_q;      // Interrupt enables, plain storage here
  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mscratch_q;
  csr_pkg::xlen_t mepc_q;
  csr_pkg::xlen_t mcause_q;
  csr_pkg::xlen_t mtval_q;
  csr_pkg::xlen_t mip_q;          // Pending bits, software-written only

  csr_pkg::xlen_t mstatus_value;
  csr_pkg::xlen_t mstatus_wr;

  // ==================================================
  // mstatus packing
  // ==================================================
  always_comb begin
    mstatus_value = '0;
    mstatus_value[csr_pkg::MSTATUS_MIE_BIT]  = mie_q;
    mstatus_value[csr_pkg::MSTATUS_MPIE_BIT] = mpie_q;
    mstatus_value[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = mpp_q;
  end

  // Drop reserved bits of an incoming mstatus write
  assign mstatus_wr = port.wr_value & csr_pkg::MSTATUS_WMASK;

  // ==================================================
  // State update
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_q      <= 1'b0;              // Interrupts off
      mpie_q     <= 1'b0;
      mpp_q      <= csr_pkg::PRIV_M;
      mie_reg_q  <= '0;
      mtvec_q    <= '0;                // Handler at address 0
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
    end else if (trap_entry) begin
      // Trap always targets M-mode
      mepc_q   <= {trap_pc[csr_pkg::XLEN-1:1], 1'b0};
      mcause_q <= {{(csr_pkg::XLEN-5){1'b0}}, trap_cause};   // Exceptions only
      mtval_q  <= trap_val;
      mpie_q   <= mie_q;               // Save enable
      mie_q    <= 1'b0;                // Block nested interrupts
      mpp_q    <= current_priv;
    end else if (mret) begin
      mie_q  <= mpie_q;                // Restore enable
      mpie_q <= 1'b1;
      mpp_q  <= csr_pkg::PRIV_M;
    end else if (port.wr_en) begin
      case (port.sel)
        csr_pkg::SEL_MSTATUS: begin
          mie_q  <= mstatus_wr[csr_pkg::MSTATUS_MIE_BIT];
          mpie_q <= mstatus_wr[csr_pkg::MSTATUS_MPIE_BIT];
          mpp_q  <= mstatus_wr[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO];
        end
        csr_pkg::SEL_MIE:      mie_reg_q  <= port.wr_value;
        csr_pkg::SEL_MTVEC:    mtvec_q    <= {port.wr_value[csr_pkg::XLEN-1:2], 2'b00};
        csr_pkg::SEL_MSCRATCH: mscratch_q <= port.wr_value;
        csr_pkg::SEL_MEPC:     mepc_q     <= {port.wr_value[csr_pkg::XLEN-1:1], 1'b0};
        csr_pkg::SEL_MCAUSE:   mcause_q   <= port.wr_value;
        csr_pkg::SEL_MTVAL:    mtval_q    <= port.wr_value;
        csr_pkg::SEL_MIP:      mip_q      <= port.wr_value;
        default: begin
          // Test window, unmapped and hardwired registers keep no state
        end
      endcase
    end
  end

  // ==================================================
  // Read path
  // ==================================================
  always_comb begin
    case (port.sel)
      csr_pkg::SEL_MSTATUS:   port.rdata = mstatus_value;
      csr_pkg::SEL_MISA:      port.rdata = csr_pkg::MISA_VALUE;
      csr_pkg::SEL_MIE:       port.rdata = mie_reg_q;
      csr_pkg::SEL_MTVEC:     port.rdata = mtvec_q;
      csr_pkg::SEL_MSCRATCH:  port.rdata = mscratch_q;
      csr_pkg::SEL_MEPC:      port.rdata = mepc_q;
      csr_pkg::SEL_MCAUSE:    port.rdata = mcause_q;
      csr_pkg::SEL_MTVAL:     port.rdata = mtval_q;
      csr_pkg::SEL_MIP:       port.rdata = mip_q;
      csr_pkg::SEL_MVENDORID: port.rdata = csr_pkg::MVENDORID_VALUE;
      csr_pkg::SEL_MARCHID:   port.rdata = csr_pkg::MARCHID_VALUE;
      csr_pkg::SEL_MIMPID:    port.rdata = csr_pkg::MIMPID_VALUE;
      csr_pkg::SEL_MHARTID:   port.rdata = csr_pkg::MHARTID_VALUE;
      default:                port.rdata = '0;       // Test window and unmapped
    endcase
  end

  // Status towards the core
  assign trap_vector = mtvec_q;       // Direct mode only
  assign mepc_out    = mepc_q;
  assign mstatus_mie = mie_q;
  assign mpp_out     = mpp_q;

  // ==================================================
  // Checks
  // ==================================================
  // Pipeline must never retire a trap and an MRET together
  a_trap_mret_excl: assert property (
    @(posedge clk) disable iff (!reset_n) !(trap_entry && mret)
  ) else $error("csr_machine_regs: trap_entry and mret in the same cycle");

  // Decoder only strobes writes for mapped registers
  a_wr_mapped: assert property (
    @(posedge clk) disable iff (!reset_n) port.wr_en |-> (port.sel != csr_pkg::SEL_NONE)
  ) else $error("csr_machine_regs: write strobe for unmapped select");

endmodule

// File: source/csr_pkg.sv
/*
 * CSR package
 * Widths, CSR addresses, operation and register-select encodings,
 * hardwired values and mstatus layout for the RV32 machine-mode CSR block
 */
package csr_pkg;

  // ==================================================
  // Widths and base types
  // ==================================================
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;      // Data word, PC, trap value
  typedef logic [11:0]     csr_addr_t;
  typedef logic [1:0]      priv_t;
  typedef logic [4:0]      cause_t;     // Exception code only

  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_M = 2'd3;

  // Privilege field inside a CSR address
  localparam int ADDR_PRIV_HI = 9;
  localparam int ADDR_PRIV_LO = 8;

  // Upper nibble of the 0x700..0x7FF test window
  localparam logic [3:0] ADDR_TEST_PAGE = 4'h7;

  // ==================================================
  // Operations (funct3)
  // ==================================================
  typedef enum logic [2:0] {
    CSR_RW  = 3'd1,
    CSR_RS  = 3'd2,
    CSR_RC  = 3'd3,
    CSR_RWI = 3'd5,   // Immediate forms act like register forms
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  // ==================================================
  // CSR addresses
  // ==================================================
  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MISA      = 12'h301;
  localparam csr_addr_t ADDR_MIE       = 12'h304;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t ADDR_MIP       = 12'h344;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;   // Info registers, read-only
  localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

  // Decoded register select, one per implemented CSR
  typedef enum logic [3:0] {
    SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC,
    SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
    SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
    SEL_TEST,         // Test window, reads zero
    SEL_NONE          // Unmapped
  } csr_sel_e;

  // ==================================================
  // Hardwired values
  // ==================================================
  localparam xlen_t MISA_VALUE      = 32'h4000_1129;  // MXL=1, I M A F D
  localparam xlen_t MVENDORID_VALUE = 32'h0;
  localparam xlen_t MARCHID_VALUE   = 32'h0;
  localparam xlen_t MIMPID_VALUE    = 32'h1;
  localparam xlen_t MHARTID_VALUE   = 32'h0;          // Single hart

  // mstatus layout
  localparam int    MSTATUS_MIE_BIT  = 3;
  localparam int    MSTATUS_MPIE_BIT = 7;
  localparam int    MSTATUS_MPP_HI   = 12;
  localparam int    MSTATUS_MPP_LO   = 11;
  localparam xlen_t MSTATUS_WMASK    = 32'h0000_1888;  // MPP, MPIE, MIE

endpackage

// File: source/csr_port_if.sv
/*
 * CSR port interface
 * Carries the decoded register select and the final write value from
 * the access decoder to the register bank, and the read value back
 */
`timescale 1ns/1ps

interface csr_port_if;

  csr_pkg::csr_sel_e sel;        // Target register, decoded once
  csr_pkg::xlen_t    rdata;      // Current value of sel
  logic              wr_en;      // Legal write, sampled at the clock edge
  csr_pkg::xlen_t    wr_value;   // Value after read-modify-write

  // Decoder side
  modport access (
    output sel,
    output wr_en,
    output wr_value,
    input  rdata
  );

  // Register bank side
  modport regs (
    input  sel,
    input  wr_en,
    input  wr_value,
    output rdata
  );

endinterface

// File: source/csr_top.sv
/*
 * Machine-mode CSR block, top level
 * Joins the access decoder and the machine register bank behind plain ports
 */
`timescale 1ns/1ps

module csr_top (
  input  logic               clk,
  input  logic               reset_n,

  // CSR instruction side
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::xlen_t     csr_wdata,      // rs1 or uimm, already resolved
  input  csr_pkg::csr_op_e   csr_op,         // funct3
  input  logic               csr_we,
  output csr_pkg::xlen_t     csr_rdata,      // Same-cycle read
  output logic               illegal_csr,

  // Trap entry
  input  logic               trap_entry,
  input  csr_pkg::xlen_t     trap_pc,
  input  csr_pkg::cause_t    trap_cause,
  input  csr_pkg::xlen_t     trap_val,
  output csr_pkg::xlen_t     trap_vector,

  // Trap return
  input  logic               mret,
  output csr_pkg::xlen_t     mepc_out,

  // Status
  input  csr_pkg::priv_t     current_priv,
  output logic               mstatus_mie,
  output csr_pkg::priv_t     mpp_out
);

  // Decoder to register bank link
  csr_port_if i_port ();

  // Address decode, checks, read-modify-write
  csr_access i_access (
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_op       (csr_op),
    .csr_we       (csr_we),
    .current_priv (current_priv),
    .illegal_csr  (illegal_csr),
    .port         (i_port.access)
  );

  // Storage, trap entry and MRET
  csr_machine_regs i_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .mret         (mret),
    .current_priv (current_priv),
    .port         (i_port.regs),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie),
    .mpp_out      (mpp_out)
  );

  // Read value straight from the selected register
  assign csr_rdata = i_port.rdata;

endmodule

// File: verification/csr_tests.svh
/*
 * Directed tests for the CSR block
 * Bus-level helpers and one task per behavior, included into the testbench
 */

// ==================================================
// Bus helpers
// ==================================================
// One-cycle CSR write, returns the same-cycle illegal flag
task automatic csr_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                         input csr_pkg::xlen_t data, output logic illegal);
  @(negedge clk);
  csr_addr  = addr;
  csr_op    = op;
  csr_wdata = data;
  csr_we    = 1'b1;
  #1;
  illegal = illegal_csr;                               // Combinational, settled
  @(negedge clk);
  csr_we = 1'b0;
endtask

task automatic csr_read(input csr_pkg::csr_addr_t addr, output csr_pkg::xlen_t value);
  @(negedge clk);
  csr_addr = addr;
  csr_we   = 1'b0;
  #1;
  value = csr_rdata;
endtask

task automatic pulse_trap(input csr_pkg::xlen_t pc, input csr_pkg::cause_t cause,
                          input csr_pkg::xlen_t val);
  @(negedge clk);
  trap_entry = 1'b1;
  trap_pc    = pc;
  trap_cause = cause;
  trap_val   = val;
  @(negedge clk);
  trap_entry = 1'b0;
endtask

// ==================================================
// Tests
// ==================================================
task automatic test_reset_values();
  int             fails_before;
  csr_pkg::xlen_t value;
  fails_before = fail_count;
  csr_read(csr_pkg::ADDR_MSTATUS, value);
  expect_equal("mstatus", value, 32'h0000_1800);       // Only MPP=M after reset
  csr_read(csr_pkg::ADDR_MTVEC, value);
  expect_equal("mtvec", value, 32'h0);
  csr_read(csr_pkg::ADDR_MEPC, value);
  expect_equal("mepc", value, 32'h0);
  csr_read(csr_pkg::ADDR_MSCRATCH, value);
  expect_equal("mscratch", value, 32'h0);
  csr_read(csr_pkg::ADDR_MISA, value);
  expect_equal("misa", value, 32'h4000_1129);
  csr_read(csr_pkg::ADDR_MIMPID, value);
  expect_equal("mimpid", value, 32'h1);
  expect_equal("mstatus_mie", {31'b0, mstatus_mie}, 32'h0);
  expect_equal("mpp_out", {30'b0, mpp_out}, 32'h3);
  if (illegal_csr !== 1'b0) report_failure("illegal_csr high with csr_we low after reset");
  finish_test("reset_values", fails_before);
endtask

task automatic test_read_modify_write();
  int               fails_before;
  csr_pkg::xlen_t   value;
  csr_pkg::xlen_t   data;
  csr_pkg::xlen_t   expected;
  csr_pkg::csr_op_e ops [6];
  logic             illegal;
  fails_before = fail_count;
  ops = '{csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC,
          csr_pkg::CSR_RWI, csr_pkg::CSR_RSI, csr_pkg::CSR_RCI};
  expected = 32'h0;
  foreach (ops[i]) begin
    data = $random(seed);
    if (ops[i] == csr_pkg::CSR_RWI || ops[i] == csr_pkg::CSR_RSI ||
        ops[i] == csr_pkg::CSR_RCI) begin
      data = data & 32'h1F;                            // uimm is 5 bits, zero-extended
    end
    csr_write(csr_pkg::ADDR_MSCRATCH, ops[i], data, illegal);
    if (illegal) report_failure("legal mscratch write flagged illegal");
    expected = rmw_model(expected, data, ops[i]);
    csr_read(csr_pkg::ADDR_MSCRATCH, value);
    expect_equal("mscratch", value, expected);
  end
  // mtvec keeps direct mode, low bits dropped
  data = $random(seed);
  csr_write(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_RW, data, illegal);
  csr_read(csr_pkg::ADDR_MTVEC, value);
  expect_equal("mtvec", value, data & 32'hFFFF_FFFC);
  expect_equal("trap_vector", trap_vector, data & 32'hFFFF_FFFC);
  // mstatus holds MIE, MPIE and MPP only
  data = $random(seed);
  csr_write(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_RW, data, illegal);
  csr_read(csr_pkg::ADDR_MSTATUS, value);
  expect_equal("mstatus", value, data & 32'h0000_1888);
  csr_write(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_RW, 32'h0000_1800, illegal);  // Back to reset
  finish_test("read_modify_write", fails_before);
endtask

task automatic test_illegal_access();
  int             fails_before;
  csr_pkg::xlen_t value;
  logic           illegal;
  fails_before = fail_count;
  csr_write(12'h3A0, csr_pkg::CSR_RW, 32'h1234_5678, illegal);   // Unmapped
  if (!illegal) report_failure("write to unmapped 0x3a0 not flagged illegal");
  csr_write(12'h7C0, csr_pkg::CSR_RW, 32'h1234_5678, illegal);   // Test window
  if (illegal) report_failure("write to test address 0x7c0 flagged illegal");
  csr_read(12'h7C0, value);
  expect_equal("csr_rdata", value, 32'h0);
  csr_write(csr_pkg::ADDR_MISA, csr_pkg::CSR_RW, 32'h0, illegal);
  if (!illegal) report_failure("write to misa not flagged illegal");
  csr_read(csr_pkg::ADDR_MISA, value);
  expect_equal("misa", value, 32'h4000_1129);
  csr_write(csr_pkg::ADDR_MHARTID, csr_pkg::CSR_RS, 32'hFFFF_FFFF, illegal);
  if (!illegal) report_failure("write to mhartid not flagged illegal");
  csr_read(csr_pkg::ADDR_MHARTID, value);
  expect_equal("mhartid", value, 32'h0);
  // User mode may not touch a machine CSR
  csr_write(csr_pkg::ADDR_MSCRATCH, csr_pkg::CSR_RW, 32'hA5A5_0F0F, illegal);
  current_priv = csr_pkg::PRIV_U;
  csr_write(csr_pkg::ADDR_MSCRATCH, csr_pkg::CSR_RW, 32'h5A5A_F0F0, illegal);
  if (!illegal) report_failure("user-mode write to mscratch not flagged illegal");
  current_priv = csr_pkg::PRIV_M;
  csr_read(csr_pkg::ADDR_MSCRATCH, value);
  expect_equal("mscratch", value, 32'hA5A5_0F0F);
  csr_read(12'h3A0, value);                            // Plain read, no write strobe
  if (illegal_csr !== 1'b0) report_failure("illegal_csr high with csr_we low");
  finish_test("illegal_access", fails_before);
endtask

task automatic test_trap_entry();
  int              fails_before;
  csr_pkg::xlen_t  value;
  csr_pkg::xlen_t  pc;
  csr_pkg::xlen_t  val;
  csr_pkg::cause_t cause;
  logic            illegal;
  fails_before = fail_count;
  csr_write(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_RW, 32'h0000_0103, illegal);
  csr_write(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_RS, 32'h0000_0008, illegal);  // MIE on
  expect_equal("mstatus_mie", {31'b0, mstatus_mie}, 32'h1);
  pc    = $random(seed);
  val   = $random(seed);
  cause = csr_pkg::cause_t'($random(seed));
  current_priv = csr_pkg::PRIV_U;
  pulse_trap(pc, cause, val);
  current_priv = csr_pkg::PRIV_M;
  expect_equal("mepc_out", mepc_out, pc & 32'hFFFF_FFFE);
  csr_read(csr_pkg::ADDR_MCAUSE, value);
  expect_equal("mcause", value, {27'b0, cause});
  csr_read(csr_pkg::ADDR_MTVAL, value);
  expect_equal("mtval", value, val);
  expect_equal("mstatus_mie", {31'b0, mstatus_mie}, 32'h0);
  csr_read(csr_pkg::ADDR_MSTATUS, value);
  expect_equal("mstatus", value, 32'h0000_0080);       // MPIE=1, MPP=U
  expect_equal("mpp_out", {30'b0, mpp_out}, 32'h0);
  expect_equal("trap_vector", trap_vector, 32'h0000_0100);
  finish_test("trap_entry", fails_before);
endtask

task automatic test_mret_priority();
  int             fails_before;
  csr_pkg::xlen_t value;
  csr_pkg::xlen_t pc;
  logic           illegal;
  fails_before = fail_count;
  @(negedge clk);
  mret = 1'b1;
  @(negedge clk);
  mret = 1'b0;
  expect_equal("mstatus_mie", {31'b0, mstatus_mie}, 32'h1);    // From MPIE
  expect_equal("mpp_out", {30'b0, mpp_out}, 32'h3);
  csr_read(csr_pkg::ADDR_MSTATUS, value);
  expect_equal("mstatus", value, 32'h0000_1888);
  // Trap and CSR write in one cycle, the write is dropped
  csr_write(csr_pkg::ADDR_MSCRATCH, csr_pkg::CSR_RW, 32'h0BAD_F00D, illegal);
  pc = $random(seed);
  @(negedge clk);
  csr_addr   = csr_pkg::ADDR_MSCRATCH;
  csr_op     = csr_pkg::CSR_RW;
  csr_wdata  = 32'hDEAD_BEEF;
  csr_we     = 1'b1;
  trap_entry = 1'b1;
  trap_pc    = pc;
  trap_cause = 5'd11;                                  // ecall from M
  trap_val   = 32'h0;
  @(negedge clk);
  csr_we     = 1'b0;
  trap_entry = 1'b0;
  csr_read(csr_pkg::ADDR_MSCRATCH, value);
  expect_equal("mscratch", value, 32'h0BAD_F00D);
  expect_equal("mepc_out", mepc_out, pc & 32'hFFFF_FFFE);
  csr_read(csr_pkg::ADDR_MCAUSE, value);
  expect_equal("mcause", value, 32'd11);
  csr_read(csr_pkg::ADDR_MSTATUS, value);
  expect_equal("mstatus", value, 32'h0000_1880);       // MIE saved, MPP=M
  finish_test("mret_priority", fails_before);
endtask

// File: verification/csr_tb.sv
/*
 * Testbench for the machine-mode CSR block
 * Clock, reset, DUT, watchdog, reference helpers and the final report
 */
`timescale 1ns/1ps

module csr_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES = 240;                    // Reset plus bound on all tests
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 1000;

  logic                clk;
  logic                reset_n;
  csr_pkg::csr_addr_t  csr_addr;
  csr_pkg::xlen_t      csr_wdata;
  csr_pkg::csr_op_e    csr_op;
  logic                csr_we;
  csr_pkg::xlen_t      csr_rdata;
  logic                illegal_csr;
  logic                trap_entry;
  csr_pkg::xlen_t      trap_pc;
  csr_pkg::cause_t     trap_cause;
  csr_pkg::xlen_t      trap_val;
  csr_pkg::xlen_t      trap_vector;
  logic                mret;
  csr_pkg::xlen_t      mepc_out;
  csr_pkg::priv_t      current_priv;
  logic                mstatus_mie;
  csr_pkg::priv_t      mpp_out;

  integer seed;
  int     pass_count;
  int     fail_count;

  always #(CLK_PERIOD / 2) clk = ~clk;

  csr_top i_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_op       (csr_op),
    .csr_we       (csr_we),
    .csr_rdata    (csr_rdata),
    .illegal_csr  (illegal_csr),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .trap_vector  (trap_vector),
    .mret         (mret),
    .mepc_out     (mepc_out),
    .current_priv (current_priv),
    .mstatus_mie  (mstatus_mie),
    .mpp_out      (mpp_out)
  );

  // ==================================================
  // Reference helpers
  // ==================================================
  // Expected CSR value after one instruction
  function automatic csr_pkg::xlen_t rmw_model(input csr_pkg::xlen_t old_value,
                                               input csr_pkg::xlen_t data,
                                               input csr_pkg::csr_op_e op);
    case (op)
      csr_pkg::CSR_RW, csr_pkg::CSR_RWI: return data;
      csr_pkg::CSR_RS, csr_pkg::CSR_RSI: return old_value | data;
      csr_pkg::CSR_RC, csr_pkg::CSR_RCI: return old_value & ~data;
      default:                           return old_value;
    endcase
  endfunction

  task automatic expect_equal(input string name, input csr_pkg::xlen_t got,
                              input csr_pkg::xlen_t expected);
    if (got !== expected) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, expected);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // Failures that are not a wrong data value
  task automatic report_failure(input string what);
    $display("error: %s", what);
    fail_count++;
  endtask

  task automatic finish_test(input string name, input int fails_before);
    $display("test %s finished with %0d errors", name, fail_count - fails_before);
  endtask

  `include "csr_tests.svh"

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    csr_op       = csr_pkg::CSR_RW;
    csr_we       = 1'b0;
    trap_entry   = 1'b0;
    trap_pc      = '0;
    trap_cause   = '0;
    trap_val     = '0;
    mret         = 1'b0;
    current_priv = csr_pkg::PRIV_M;
    seed         = 32'h2d0;
    pass_count   = 0;
    fail_count   = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;                                    // Release away from the rising edge

    test_reset_values();
    test_read_modify_write();
    test_illegal_access();
    test_trap_entry();
    test_mret_priority();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog against a hung test
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

endmodule
